/* bench/cu_chk.sv */
`timescale 1ns/1ns

module cu_chk (
    input logic              clk,
    input logic              reset,
    input cu_pkg::cu_state_t state,
    input cu_pkg::cu_ctrl_t  ctrl
);
    import cu_pkg::*;

    int fail_count = 0;  // failed assertions so far

    // a register write and a ram write never share a cycle
    we_store_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.we && ctrl.mem_enable))
    else begin
        $error("we and mem_enable are high in the same cycle");
        fail_count++;
    end

    ir_load_with_fetch: assert property (@(posedge clk) disable iff (reset)
        ctrl.load_ir |-> (ctrl.load_rom && ctrl.increment))
    else begin
        $error("load_ir is high without load_rom and increment");
        fail_count++;
    end

    reset_leaves_fetch: assert property (@(posedge clk)
        $fell(reset) |-> state == FETCH_OPCODE ##1 state != FETCH_OPCODE)
    else begin
        $error("state did not leave FETCH_OPCODE right after reset");
        fail_count++;
    end

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
    output logic clk
);
    localparam int HALF_PERIOD = 4;  // 8 ns period

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

/* bench/tb_cpu_cu.sv */
`timescale 1ns/1ns

module tb_cpu_cu;
    import isa_pkg::*;
    import cu_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_INSTR    = 200;
    localparam int HALT_CYCLES  = 50;
    localparam int POOL_SIZE    = 21;
    localparam int WATCHDOG_NS  =
        (2 * RESET_CYCLES + (NUM_INSTR + 1) * 6 + HALT_CYCLES + 20) * CLK_PERIOD;

    logic     clk;
    logic     reset;
    instr_t   ir;      // plays the external ir register
    logic     z_flag;
    logic     c_flag;
    cu_ctrl_t ctrl;

    int       step;       // cycle index within the instruction where 0 is the opcode fetch
    bit       checking;
    string    test_name;
    integer   seed;
    opcode_t  op_pool [0:POOL_SIZE-1];

    tb_clock u_clock (
        .clk (clk)
    );

    cpu_cu dut (
        .clk    (clk),
        .reset  (reset),
        .ir     (ir),
        .z_flag (z_flag),
        .c_flag (c_flag),
        .ctrl   (ctrl)
    );

    bind cpu_cu cu_chk u_chk (
        .clk   (clk),
        .reset (reset),
        .state (state),
        .ctrl  (ctrl)
    );

    // cycles from one opcode fetch to the next
    function automatic int instr_len(opcode_t op);
        case (op)
            OP_ST_IND     : return 3;
            OP_LD, OP_LDC : return 5;
            OP_DJNZ       : return 6;
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADC, OP_XOR, OP_NOT, OP_SHL, OP_SHR,
            OP_INC_B, OP_ADD_A, OP_LD_IND, OP_ST, OP_JMP, OP_JC : return 4;
            default       : return 2;  // no-op and unknown opcodes
        endcase
    endfunction

    function automatic cu_ctrl_t expected_ctrl(instr_t i, logic z, logic c, int s);
        cu_ctrl_t    e;
        reg_sel_t    rsel;
        st_src_t     ssrc;
        alu_op_t     op;
        alu_in_sel_t isel;
        e    = '0;
        op   = ALU_NONE;
        isel = ALU_IN_RDA_RDB;
        rsel = RSEL_A;
        ssrc = ST_A;
        if (i.reg_addr == REG_B) begin
            rsel = RSEL_B;
            ssrc = ST_B;
        end else if (i.reg_addr == REG_ACC) begin
            rsel = RSEL_ACC;
            ssrc = ST_ACC;
        end else if (i.reg_addr == REG_COUNT) begin
            rsel = RSEL_COUNT;  // count is never a store source so a stays selected
        end
        case (i.opcode)
            OP_ADD, OP_INC_B, OP_ADD_A : op = ALU_ADD;
            OP_SUB, OP_DJNZ            : op = ALU_SUB;
            OP_AND                     : op = ALU_AND;
            OP_OR                      : op = ALU_OR;
            OP_ADC                     : op = ALU_ADC;
            OP_XOR                     : op = ALU_XOR;
            OP_SHL                     : op = ALU_SHL;
            OP_SHR                     : op = ALU_SHR;
            OP_NOT : begin
                if (i.reg_addr == REG_A) begin
                    op = ALU_NOTA;
                end else if (i.reg_addr == REG_B) begin
                    op = ALU_NOTB;
                end
            end
            default : op = ALU_NONE;
        endcase
        if (i.opcode == OP_INC_B) isel = ALU_IN_RDB_ONE;
        if (i.opcode == OP_ADD_A) isel = ALU_IN_ACC_A;
        if (i.opcode == OP_DJNZ) isel = ALU_IN_COUNT_ONE;

        if (s == 0) begin
            e.load_ir   = 1'b1;
            e.load_rom  = 1'b1;
            e.increment = 1'b1;
            return e;
        end
        if (s == 1 || i.opcode == OP_HALT) begin
            return e;  // decode cycle and halted drive nothing
        end

        case (i.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADC, OP_XOR, OP_NOT, OP_SHL, OP_SHR,
            OP_INC_B, OP_ADD_A, OP_DJNZ : begin
                if (s == 2) begin
                    e.ope           = op;
                    e.alu_input_sel = isel;
                end else if (s == 3) begin
                    e.we                   = 1'b1;
                    e.reg_sel              = rsel;
                    e.reg_write_source_sel = WB_ALU;
                end else if (s == 4) begin
                    e.load_rom  = 1'b1;  // djnz target operand
                    e.increment = 1'b1;
                end else if (s == 5) begin
                    e.jumper = ~z;
                end
            end
            OP_LD, OP_LDC, OP_ST, OP_JMP, OP_JC : begin
                if (s == 2) begin
                    e.load_rom  = 1'b1;
                    e.increment = 1'b1;
                end else if (s == 3 && i.opcode == OP_ST) begin
                    e.mem_enable          = 1'b1;
                    e.ram_read_source_sel = ssrc;
                    e.adress_sel          = ADDR_OPERAND;
                end else if (s == 3 && i.opcode == OP_JMP) begin
                    e.jumper = z;
                end else if (s == 3 && i.opcode == OP_JC) begin
                    e.jumper = c;
                end else if (s == 4) begin
                    e.we                   = 1'b1;
                    e.reg_sel              = rsel;
                    e.reg_write_source_sel = (i.opcode == OP_LDC) ? WB_ROM : WB_RAM;
                end
            end
            OP_LD_IND : begin
                if (s == 3) begin
                    e.we                   = 1'b1;
                    e.reg_sel              = rsel;
                    e.reg_write_source_sel = WB_RAM;
                    e.adress_sel           = ADDR_RDB;
                end
            end
            OP_ST_IND : begin
                e.mem_enable          = 1'b1;
                e.ram_read_source_sel = ssrc;
                e.adress_sel          = ADDR_RDB;
            end
            default : e = '0;
        endcase
        return e;
    endfunction

    task automatic check_value(string name, cu_ctrl_t expected, cu_ctrl_t actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "control word mismatch");
        end
    endtask

    task automatic apply_reset(string name);
        checking  = 1'b0;
        test_name = name;
        reset     = 1'b1;
        @(negedge clk);
        step     = 0;  // state sits in FETCH_OPCODE from here on
        checking = 1'b1;
        repeat (RESET_CYCLES - 1) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic run_instruction(instr_t i, logic z, logic c);
        int len;
        len = instr_len(i.opcode);
        @(negedge clk);  // ir was captured at the last edge
        ir     = i;
        z_flag = z;
        c_flag = c;
        step   = 1;
        repeat (len - 2) begin
            @(negedge clk);
            step = step + 1;
        end
        @(negedge clk);
        step = 0;
    endtask

    task automatic random_instruction(int n);
        instr_t      i;
        logic [31:0] rnd;
        logic        z;
        logic        c;
        rnd        = $random(seed);
        i.opcode   = op_pool[$unsigned(rnd) % POOL_SIZE];
        rnd        = $random(seed);
        i.reg_addr = reg_addr_t'(1 + $unsigned(rnd) % 4);
        rnd        = $random(seed);
        z          = rnd[0];
        c          = rnd[1];
        test_name  = $sformatf("instr %0d op %05b reg %03b", n, i.opcode, i.reg_addr);
        run_instruction(i, z, c);
    endtask

    always @(posedge clk) begin
        if (checking) begin
            check_value($sformatf("%s step %0d", test_name, step),
                        expected_ctrl(ir, z_flag, c_flag, step), ctrl);
        end
        if (dut.u_chk.fail_count != 0) begin
            $display("a control word assertion failed");
            $display("TESTS FAILED");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("the run timed out after %0d ns", WATCHDOG_NS);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset     = 1'b1;
        ir        = '0;
        z_flag    = 1'b0;
        c_flag    = 1'b0;
        step      = 0;
        checking  = 1'b0;
        test_name = "reset";
        seed      = 94;
        op_pool   = '{OP_ADD, OP_SUB, OP_LD, OP_ST, OP_LDC, OP_JMP, OP_AND,
                      OP_OR, OP_JC, OP_ADC, OP_XOR, OP_NOT, OP_SHL, OP_SHR,
                      OP_LD_IND, OP_INC_B, OP_ADD_A, OP_DJNZ, OP_ST_IND,
                      5'b00000, 5'b11111};  // last two decode as no-op

        apply_reset("reset");
        for (int n = 0; n < NUM_INSTR; n++) begin
            random_instruction(n);
        end

        test_name = "halt";
        @(negedge clk);
        ir   = {OP_HALT, REG_A};
        step = 1;
        repeat (HALT_CYCLES) begin
            @(negedge clk);
            step = step + 1;  // every cycle past decode stays all zero
        end

        apply_reset("reset after halt");
        random_instruction(NUM_INSTR);
        @(negedge clk);

        if (dut.u_chk.fail_count != 0) begin
            $display("a control word assertion failed");
            $display("TESTS FAILED");
            $fatal(1, "assertion failure");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

/* sources.f */
verilog/isa_pkg.sv
verilog/cu_pkg.sv
verilog/instr_decoder.sv
verilog/cu_sequencer.sv
verilog/ctrl_gen.sv
verilog/cpu_cu.sv
bench/tb_clock.sv
bench/cu_chk.sv
bench/tb_cpu_cu.sv

/* verilog/cpu_cu.sv */
`timescale 1ns/1ns

module cpu_cu (
    input  logic             clk,
    input  logic             reset,
    input  isa_pkg::instr_t  ir,      // held by the external ir register
    input  logic             z_flag,
    input  logic             c_flag,
    output cu_pkg::cu_ctrl_t ctrl
);
    import cu_pkg::*;

    dec_t      dec;
    cu_state_t state;

    instr_decoder u_decoder (
        .ir  (ir),
        .dec (dec)
    );

    cu_sequencer u_sequencer (
        .clk   (clk),
        .reset (reset),
        .dec   (dec),
        .state (state)
    );

    ctrl_gen u_ctrl_gen (
        .state  (state),
        .dec    (dec),
        .z_flag (z_flag),
        .c_flag (c_flag),
        .ctrl   (ctrl)
    );

endmodule

/* verilog/ctrl_gen.sv */
`timescale 1ns/1ns

module ctrl_gen (
    input  cu_pkg::cu_state_t state,
    input  cu_pkg::dec_t      dec,
    input  logic              z_flag,
    input  logic              c_flag,
    output cu_pkg::cu_ctrl_t  ctrl
);
    import cu_pkg::*;

    always_comb begin
        ctrl = '0;

        case (state)
            FETCH_OPCODE : begin
                ctrl.load_rom  = 1'b1;
                ctrl.load_ir   = 1'b1;
                ctrl.increment = 1'b1;
            end

            FETCH_OPERAND : begin
                ctrl.load_rom  = 1'b1;  // operand byte, ir keeps the opcode
                ctrl.increment = 1'b1;
            end

            EXECUTE_ADD,
            EXECUTE_SUB,
            EXECUTE_AND,
            EXECUTE_OR,
            EXECUTE_ADC,
            EXECUTE_XOR,
            EXECUTE_SHL,
            EXECUTE_SHR,
            EXECUTE_NOT : begin
                ctrl.ope           = dec.ope;
                ctrl.alu_input_sel = dec.alu_in_sel;
            end

            EXECUTE_ST : begin
                ctrl.mem_enable          = 1'b1;
                ctrl.ram_read_source_sel = dec.st_src;
                ctrl.adress_sel          = dec.addr_sel;  // operand or b
            end

            EXECUTE_JMP : begin
                ctrl.jumper = z_flag;
            end

            EXECUTE_JC : begin
                ctrl.jumper = c_flag;
            end

            EXECUTE_DJNZ : begin
                ctrl.jumper = ~z_flag;  // flag comes from the count decrement
            end

            WRITE_BACK : begin
                ctrl.we                   = 1'b1;
                ctrl.reg_sel              = dec.reg_sel;
                ctrl.reg_write_source_sel = dec.wb_src;
                ctrl.adress_sel           = dec.addr_sel;
            end

            // decode, ld and ldc execute and halted drive nothing
            default : begin
                ctrl = '0;
            end
        endcase
    end

endmodule

/* verilog/cu_pkg.sv */
package cu_pkg;

    typedef enum logic [4:0] {
        FETCH_OPCODE  = 5'b00000,  // rom word into ir, pc advances
        DECODE        = 5'b00001,
        FETCH_OPERAND = 5'b00010,  // operand byte from rom
        EXECUTE_LD    = 5'b00011,
        EXECUTE_ST    = 5'b00100,
        EXECUTE_LDC   = 5'b00101,
        EXECUTE_ADD   = 5'b00110,
        EXECUTE_JMP   = 5'b00111,
        EXECUTE_SUB   = 5'b01000,
        EXECUTE_AND   = 5'b01001,
        EXECUTE_OR    = 5'b01010,
        EXECUTE_ADC   = 5'b01011,
        EXECUTE_XOR   = 5'b01100,
        EXECUTE_SHL   = 5'b01101,
        EXECUTE_SHR   = 5'b01110,
        EXECUTE_NOT   = 5'b01111,
        EXECUTE_JC    = 5'b10000,
        EXECUTE_DJNZ  = 5'b10101,
        HALTED        = 5'b10110,  // held until reset
        WRITE_BACK    = 5'b10111
    } cu_state_t;

    typedef logic [1:0] alu_in_sel_t;
    typedef logic [1:0] wb_src_t;
    typedef logic [1:0] addr_sel_t;
    typedef logic [1:0] st_src_t;
    typedef logic [1:0] reg_sel_t;

    localparam alu_in_sel_t ALU_IN_RDA_RDB   = 2'd0;
    localparam alu_in_sel_t ALU_IN_RDB_ONE   = 2'd1;
    localparam alu_in_sel_t ALU_IN_ACC_A     = 2'd2;
    localparam alu_in_sel_t ALU_IN_COUNT_ONE = 2'd3;

    localparam wb_src_t WB_RAM = 2'd0;  // ram data out
    localparam wb_src_t WB_ROM = 2'd1;  // constant on rom data out
    localparam wb_src_t WB_ALU = 2'd2;

    localparam addr_sel_t ADDR_OPERAND = 2'd0;
    localparam addr_sel_t ADDR_RDB     = 2'd1;

    localparam st_src_t ST_A   = 2'd0;
    localparam st_src_t ST_B   = 2'd1;
    localparam st_src_t ST_ACC = 2'd3;

    localparam reg_sel_t RSEL_A     = 2'd0;
    localparam reg_sel_t RSEL_B     = 2'd1;
    localparam reg_sel_t RSEL_ACC   = 2'd2;
    localparam reg_sel_t RSEL_COUNT = 2'd3;

    typedef struct packed {
        cu_state_t        after_decode;
        cu_state_t        after_operand;
        logic             loops_back;  // djnz returns to operand fetch
        isa_pkg::alu_op_t ope;
        alu_in_sel_t      alu_in_sel;
        wb_src_t          wb_src;
        addr_sel_t        addr_sel;
        st_src_t          st_src;
        reg_sel_t         reg_sel;
    } dec_t;

    typedef struct packed {
        logic             load_ir;
        logic             load_rom;
        logic             increment;
        logic             jumper;
        logic             we;
        logic             mem_enable;
        isa_pkg::alu_op_t ope;
        reg_sel_t         reg_sel;
        wb_src_t          reg_write_source_sel;
        st_src_t          ram_read_source_sel;
        addr_sel_t        adress_sel;
        alu_in_sel_t      alu_input_sel;
    } cu_ctrl_t;

endpackage

/* verilog/cu_sequencer.sv */
`timescale 1ns/1ns

module cu_sequencer (
    input  logic              clk,
    input  logic              reset,
    input  cu_pkg::dec_t      dec,
    output cu_pkg::cu_state_t state
);
    import cu_pkg::*;

    cu_state_t state_next;

    always_comb begin
        state_next = FETCH_OPCODE;
        case (state)
            FETCH_OPCODE : begin
                state_next = DECODE;
            end
            DECODE : begin
                state_next = dec.after_decode;
            end
            FETCH_OPERAND : begin
                state_next = dec.after_operand;
            end
            EXECUTE_ADD,
            EXECUTE_SUB,
            EXECUTE_AND,
            EXECUTE_OR,
            EXECUTE_ADC,
            EXECUTE_XOR,
            EXECUTE_SHL,
            EXECUTE_SHR,
            EXECUTE_NOT,
            EXECUTE_LD,
            EXECUTE_LDC : begin
                state_next = WRITE_BACK;  // result lands in the register file
            end
            EXECUTE_ST,
            EXECUTE_JMP,
            EXECUTE_JC,
            EXECUTE_DJNZ : begin
                state_next = FETCH_OPCODE;
            end
            WRITE_BACK : begin
                if (dec.loops_back) begin
                    state_next = FETCH_OPERAND;  // djnz still needs its target
                end else begin
                    state_next = FETCH_OPCODE;
                end
            end
            HALTED : begin
                state_next = HALTED;
            end
            default : begin
                state_next = FETCH_OPCODE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH_OPCODE;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* verilog/instr_decoder.sv */
`timescale 1ns/1ns

module instr_decoder (
    input  isa_pkg::instr_t ir,
    output cu_pkg::dec_t    dec
);
    import isa_pkg::*;
    import cu_pkg::*;

    always_comb begin
        dec = '0;
        dec.after_decode  = FETCH_OPCODE;  // unknown opcodes fall back to fetch
        dec.after_operand = FETCH_OPCODE;
        dec.ope           = ALU_NONE;
        dec.alu_in_sel    = ALU_IN_RDA_RDB;
        dec.wb_src        = WB_ALU;
        dec.addr_sel      = ADDR_OPERAND;

        case (ir.opcode)
            OP_ADD : begin
                dec.after_decode = EXECUTE_ADD;
                dec.ope          = ALU_ADD;
            end
            OP_INC_B : begin
                dec.after_decode = EXECUTE_ADD;
                dec.ope          = ALU_ADD;
                dec.alu_in_sel   = ALU_IN_RDB_ONE;
            end
            OP_ADD_A : begin
                dec.after_decode = EXECUTE_ADD;
                dec.ope          = ALU_ADD;
                dec.alu_in_sel   = ALU_IN_ACC_A;
            end
            OP_SUB : begin
                dec.after_decode = EXECUTE_SUB;
                dec.ope          = ALU_SUB;
            end
            OP_DJNZ : begin
                dec.after_decode  = EXECUTE_SUB;  // count minus one first
                dec.after_operand = EXECUTE_DJNZ;
                dec.loops_back    = 1'b1;
                dec.ope           = ALU_SUB;
                dec.alu_in_sel    = ALU_IN_COUNT_ONE;
            end
            OP_AND : begin
                dec.after_decode = EXECUTE_AND;
                dec.ope          = ALU_AND;
            end
            OP_OR : begin
                dec.after_decode = EXECUTE_OR;
                dec.ope          = ALU_OR;
            end
            OP_ADC : begin
                dec.after_decode = EXECUTE_ADC;
                dec.ope          = ALU_ADC;
            end
            OP_XOR : begin
                dec.after_decode = EXECUTE_XOR;
                dec.ope          = ALU_XOR;
            end
            OP_SHL : begin
                dec.after_decode = EXECUTE_SHL;
                dec.ope          = ALU_SHL;
            end
            OP_SHR : begin
                dec.after_decode = EXECUTE_SHR;
                dec.ope          = ALU_SHR;
            end
            OP_NOT : begin
                dec.after_decode = EXECUTE_NOT;
                if (ir.reg_addr == REG_A) begin
                    dec.ope = ALU_NOTA;
                end else if (ir.reg_addr == REG_B) begin
                    dec.ope = ALU_NOTB;
                end
            end
            OP_LD : begin
                dec.after_decode  = FETCH_OPERAND;
                dec.after_operand = EXECUTE_LD;
                dec.wb_src        = WB_RAM;
            end
            OP_LD_IND : begin
                dec.after_decode = EXECUTE_LD;  // address already in b, no operand
                dec.wb_src       = WB_RAM;
                dec.addr_sel     = ADDR_RDB;
            end
            OP_LDC : begin
                dec.after_decode  = FETCH_OPERAND;
                dec.after_operand = EXECUTE_LDC;
                dec.wb_src        = WB_ROM;
            end
            OP_ST : begin
                dec.after_decode  = FETCH_OPERAND;
                dec.after_operand = EXECUTE_ST;
            end
            OP_ST_IND : begin
                dec.after_decode = EXECUTE_ST;
                dec.addr_sel     = ADDR_RDB;
            end
            OP_JMP : begin
                dec.after_decode  = FETCH_OPERAND;
                dec.after_operand = EXECUTE_JMP;
            end
            OP_JC : begin
                dec.after_decode  = FETCH_OPERAND;
                dec.after_operand = EXECUTE_JC;
            end
            OP_HALT : begin
                dec.after_decode = HALTED;
            end
            default : begin
                dec.after_decode = FETCH_OPCODE;
            end
        endcase

        case (ir.reg_addr)
            REG_A     : dec.reg_sel = RSEL_A;
            REG_B     : dec.reg_sel = RSEL_B;
            REG_ACC   : dec.reg_sel = RSEL_ACC;
            REG_COUNT : dec.reg_sel = RSEL_COUNT;
            default   : dec.reg_sel = RSEL_A;
        endcase

        case (ir.reg_addr)
            REG_B   : dec.st_src = ST_B;
            REG_ACC : dec.st_src = ST_ACC;
            default : dec.st_src = ST_A;
        endcase
    end

endmodule

/* verilog/isa_pkg.sv */
package isa_pkg;

    typedef logic [4:0] opcode_t;     // upper five bits of the instruction word
    typedef logic [2:0] reg_addr_t;   // register field, lower three bits
    typedef logic [3:0] alu_op_t;     // operation code sent to the ALU

    // opcodes, values fixed by the ISA
    localparam opcode_t OP_ADD    = 5'b00001;
    localparam opcode_t OP_SUB    = 5'b00010;
    localparam opcode_t OP_LD     = 5'b00011;  // ram[operand] to register
    localparam opcode_t OP_ST     = 5'b00100;  // register to ram[operand]
    localparam opcode_t OP_LDC    = 5'b00101;  // constant from rom
    localparam opcode_t OP_JMP    = 5'b00110;  // jump when zero flag set
    localparam opcode_t OP_AND    = 5'b00111;
    localparam opcode_t OP_OR     = 5'b01000;
    localparam opcode_t OP_JC     = 5'b01001;  // jump when carry flag set
    localparam opcode_t OP_ADC    = 5'b01010;
    localparam opcode_t OP_XOR    = 5'b01011;
    localparam opcode_t OP_NOT    = 5'b01100;
    localparam opcode_t OP_SHL    = 5'b01101;
    localparam opcode_t OP_SHR    = 5'b01110;
    localparam opcode_t OP_LD_IND = 5'b01111;  // ram[b] to register
    localparam opcode_t OP_INC_B  = 5'b10000;
    localparam opcode_t OP_ADD_A  = 5'b10001;  // acc plus a
    localparam opcode_t OP_DJNZ   = 5'b10010;  // decrement count, jump if not zero
    localparam opcode_t OP_HALT   = 5'b10111;
    localparam opcode_t OP_ST_IND = 5'b11000;  // register to ram[b]

    // register file addresses
    localparam reg_addr_t REG_A     = 3'b001;
    localparam reg_addr_t REG_B     = 3'b010;
    localparam reg_addr_t REG_ACC   = 3'b011;
    localparam reg_addr_t REG_COUNT = 3'b100;

    // ALU operations
    localparam alu_op_t ALU_NONE = 4'b0000;
    localparam alu_op_t ALU_ADD  = 4'b0001;
    localparam alu_op_t ALU_SUB  = 4'b0010;
    localparam alu_op_t ALU_AND  = 4'b0011;
    localparam alu_op_t ALU_OR   = 4'b0100;
    localparam alu_op_t ALU_ADC  = 4'b0101;
    localparam alu_op_t ALU_XOR  = 4'b0110;
    localparam alu_op_t ALU_SHL  = 4'b0111;
    localparam alu_op_t ALU_SHR  = 4'b1000;
    localparam alu_op_t ALU_NOTA = 4'b1001;  // invert register a
    localparam alu_op_t ALU_NOTB = 4'b1010;  // invert register b

    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t reg_addr;
    } instr_t;

endpackage
